// ==== sprite_rom.hex ====
// One sprite row per line, top row first
// Sixteen RGB565 words per row, column 0 in the leftmost four digits
F81FF81FF81FF81FF81F294529452945294529452945F81FF81FF81FF81FF81F
F81FF81FF81FF81F294507E007E007E007E007E007E02945F81FF81FF81FF81F
F81FF81FF81F294507E007E0F80007E007E0F80007E007E02945F81FF81FF81F
F81FF81F294507E007E007E007E007E007E007E007E007E007E02945F81FF81F
F81F294507E007E007E0FFFFFFFF07E007E0FFFFFFFF07E007E007E02945F81F
F81F294507E007E007E0FFFF294507E007E0FFFF294507E007E007E02945F81F
294507E007E007E007E007E007E007E007E007E007E007E007E007E007E02945
294507E007E0841F841F841F841F841F841F841F841F841F841F07E007E02945
294507E007E0841FFD20FD20FD20FD20FD20FD20FD20FD20841F07E007E02945
294507E007E0841F841F841F841F841F841F841F841F841F841F07E007E02945
F81F294507E007E007E007E007E007E007E007E007E007E007E007E02945F81F
F81F294507E007E007E007E007E007E007E007E007E007E007E007E02945F81F
F81FF81F294507E007E007E0294529452945294507E007E007E02945F81FF81F
F81FF81F2945F800F8002945F81FF81FF81FF81F2945F800F8002945F81FF81F
F81FF81F2945F800F8002945F81FF81FF81FF81F2945F800F8002945F81FF81F
F81FF81FF81F29452945F81FF81FF81FF81FF81FF81F29452945F81FF81FF81F

// ==== vga_game.f ====
+incdir+.
bus_pkg.sv
display_pkg.sv
display_ifs.sv
vga_timing.sv
control_regs.sv
sky_ground.sv
sprite_layer.sv
score_overlay.sv
vga_game_top.sv
tb_vga_game.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the VGA game testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_vga_game -f vga_game.f \
    && ./obj_dir/Vtb_vga_game | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== tb_vga_game.sv ====
`timescale 1ns/100ps
`include "vga_params.svh"

module tb_vga_game;
    import display_pkg::*;
    import bus_pkg::*;

    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RUN_FRAMES = 5;
    localparam int NUM_GOALS = 12;

    // Pixel categories of the expected image
    localparam logic [3:0] K_BLANK  = 4'd0;
    localparam logic [3:0] K_DAY    = 4'd1;
    localparam logic [3:0] K_NIGHT  = 4'd2;
    localparam logic [3:0] K_LINE   = 4'd3;
    localparam logic [3:0] K_LIGHT  = 4'd4;
    localparam logic [3:0] K_DARK   = 4'd5;
    localparam logic [3:0] K_SPRITE = 4'd6;
    localparam logic [3:0] K_KEY    = 4'd7;
    localparam logic [3:0] K_DIGIT  = 4'd8;

    typedef struct packed {
        logic [10:0] h;
        logic [9:0]  v;
        logic [3:0]  frame;
        logic        hs;
        logic        vs;
        logic        blank_n;
        logic [23:0] rgb;
        logic [3:0]  kind;
        logic        on_sprite;
    } expect_t;

    bit                    clk;
    logic                  reset;
    logic                  chipselect;
    logic                  write;
    logic [BUS_ADDR_W-1:0] address;
    logic [BUS_DATA_W-1:0] writedata;
    logic [7:0]            vga_r, vga_g, vga_b;
    logic                  vga_hs, vga_vs, vga_blank_n, vga_clk;

    // Raster model
    int          m_h, m_v, m_frame;
    logic [10:0] m_sprite_x, m_sprite_y, m_score_x, m_score_y;
    logic [3:0]  m_score;
    expect_t     pipe1, pipe2;
    logic [255:0] rom_model [0:`SPRITE_SIZE-1];
    logic [63:0]  font_tbl [0:9];
    int           cov [NUM_GOALS] = '{default: 0};

    vga_game_top vga_game_top_inst (
        .clk         (clk),
        .reset       (reset),
        .chipselect  (chipselect),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_clk     (vga_clk)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    initial begin
        $readmemh("sprite_rom.hex", rom_model);
        // 8x8 digit glyphs with the top row in the high byte and bit 7 as the left column
        font_tbl[0] = 64'h3C666E7E76663C00;
        font_tbl[1] = 64'h1838181818187E00;
        font_tbl[2] = 64'h3C66061C30667E00;
        font_tbl[3] = 64'h3C66061C06663C00;
        font_tbl[4] = 64'h0C1C2C4C7E0C0C00;
        font_tbl[5] = 64'h7E607C0606663C00;
        font_tbl[6] = 64'h3C66607C66663C00;
        font_tbl[7] = 64'h7E060C1830303000;
        font_tbl[8] = 64'h3C66663C66663C00;
        font_tbl[9] = 64'h3C66663E06663C00;
    end

    function automatic expect_t idle_entry();
        expect_t e;
        e = '0;
        e.hs = 1'b1;
        e.vs = 1'b1;
        e.kind = K_BLANK;
        return e;
    endfunction

    function automatic expect_t compute_expected(input int h, input int v, input int frame);
        expect_t     e;
        pixel565_u   word;
        logic [23:0] color;
        logic [63:0] glyph;
        logic        night;
        int          sc, sr, dc, dr;
        e = '0;
        e.h = 11'(h);
        e.v = 10'(v);
        e.frame = 4'(frame);
        e.hs = !((h >= H_SYNC_START) && (h < H_SYNC_START + `H_SYNC));
        e.vs = !((v >= V_SYNC_START) && (v < V_SYNC_START + `V_SYNC));
        e.blank_n = (h < `H_ACTIVE) && (v < `V_ACTIVE);
        e.kind = K_BLANK;
        color = 24'h000000;
        if (e.blank_n) begin
            // Two day frames and then two night frames
            night = ((frame / `DAY_NIGHT_FRAMES) % 2) == 1;
            if (v <= `SKY_LAST_ROW) begin
                color = night ? {`SKY_NIGHT_R, `SKY_NIGHT_G, `SKY_NIGHT_B}
                              : {`SKY_DAY_R, `SKY_DAY_G, `SKY_DAY_B};
                e.kind = night ? K_NIGHT : K_DAY;
            end else if (v == `GROUND_LINE_ROW) begin
                color = 24'h000000;
                e.kind = K_LINE;
            end else if (v <= `LIGHT_GROUND_LAST_ROW) begin
                color = {`LIGHT_GROUND_R, `LIGHT_GROUND_G, `LIGHT_GROUND_B};
                e.kind = K_LIGHT;
            end else begin
                color = {`DARK_GROUND_R, `DARK_GROUND_G, `DARK_GROUND_B};
                e.kind = K_DARK;
            end
            sc = h - int'(m_sprite_x);
            sr = v - int'(m_sprite_y);
            if (sc >= 0 && sc < `SPRITE_SIZE && sr >= 0 && sr < `SPRITE_SIZE) begin
                e.on_sprite = 1'b1;
                word.raw = rom_model[sr][(`SPRITE_SIZE - 1 - sc) * 16 +: 16];
                if (word.raw == `TRANSPARENT_KEY_A || word.raw == `TRANSPARENT_KEY_B) begin
                    e.kind = K_KEY;
                end else begin
                    color = {word.fields.red, 3'b000, word.fields.green, 2'b00,
                             word.fields.blue, 3'b000};
                    e.kind = K_SPRITE;
                end
            end
            dc = h - int'(m_score_x);
            dr = v - int'(m_score_y);
            if (m_score <= 4'd9 && dc >= 0 && dc < `FONT_SIZE && dr >= 0 && dr < `FONT_SIZE) begin
                glyph = font_tbl[m_score];
                if (glyph[63 - dr * 8 - dc]) begin
                    color = 24'h000000;
                    e.kind = K_DIGIT;
                end
            end
        end
        e.rgb = color;
        return e;
    endfunction

    // Scan counters, register mirror and the two-clock expected pipeline
    always @(posedge clk) begin
        if (reset) begin
            m_h <= 0;
            m_v <= 0;
            m_frame <= 0;
            pipe1 <= idle_entry();
            pipe2 <= idle_entry();
            m_sprite_x <= 11'd100;
            m_sprite_y <= 11'd248;
            m_score <= 4'd0;
            m_score_x <= 11'd25;
            m_score_y <= 11'd41;
        end else begin
            pipe1 <= compute_expected(m_h, m_v, m_frame);
            pipe2 <= pipe1;
            if (m_h == H_TOTAL - 1) begin
                m_h <= 0;
                if (m_v == V_TOTAL - 1) begin
                    m_v <= 0;
                    m_frame <= m_frame + 1;
                end else begin
                    m_v <= m_v + 1;
                end
            end else begin
                m_h <= m_h + 1;
            end
            if (chipselect && write) begin
                case (address)
                    REG_SPRITE_X: m_sprite_x <= writedata[10:0];
                    REG_SPRITE_Y: m_sprite_y <= writedata[10:0];
                    REG_SCORE:    m_score <= writedata[3:0];
                    REG_SCORE_X:  m_score_x <= writedata[10:0];
                    REG_SCORE_Y:  m_score_y <= writedata[10:0];
                    default: ;
                endcase
            end
        end
    end

    task automatic report_error(input string msg);
        $display("ERROR %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "wait limit exceeded");
    endtask

    // Outputs sampled mid-cycle away from the rising edge
    always @(negedge clk) begin
        hs_check: assert (vga_hs === pipe2.hs) else
            report_error($sformatf("vga_hs %b, expected %b at h=%0d v=%0d",
                                   vga_hs, pipe2.hs, pipe2.h, pipe2.v));
        vs_check: assert (vga_vs === pipe2.vs) else
            report_error($sformatf("vga_vs %b, expected %b at h=%0d v=%0d",
                                   vga_vs, pipe2.vs, pipe2.h, pipe2.v));
        blank_check: assert (vga_blank_n === pipe2.blank_n) else
            report_error($sformatf("vga_blank_n %b, expected %b at h=%0d v=%0d",
                                   vga_blank_n, pipe2.blank_n, pipe2.h, pipe2.v));
        black_check: assert (vga_blank_n || {vga_r, vga_g, vga_b} === 24'h000000) else
            report_error($sformatf("rgb %06h while blanked", {vga_r, vga_g, vga_b}));
        rgb_check: assert ({vga_r, vga_g, vga_b} === pipe2.rgb) else
            report_error($sformatf("rgb %06h, expected %06h (kind %0d) at h=%0d v=%0d frame %0d",
                                   {vga_r, vga_g, vga_b}, pipe2.rgb, pipe2.kind,
                                   pipe2.h, pipe2.v, pipe2.frame));
        clk_out_check: assert (vga_clk === 1'(m_h % 2)) else
            report_error($sformatf("vga_clk %b at hcount %0d", vga_clk, m_h));

        if (pipe2.kind == K_DAY && pipe2.frame <= 1) cov[0]++;
        if (pipe2.kind == K_LINE) cov[1]++;
        if (pipe2.kind == K_LIGHT) cov[2]++;
        if (pipe2.kind == K_DARK) cov[3]++;
        if (pipe2.kind == K_NIGHT && pipe2.frame >= 2 && pipe2.frame <= 3) cov[4]++;
        if (pipe2.kind == K_DAY && pipe2.frame == 4) cov[5]++;
        if (pipe2.kind == K_SPRITE && pipe2.frame >= 1) cov[6]++;
        if (pipe2.kind == K_KEY && pipe2.frame >= 1) cov[7]++;
        if (pipe2.kind == K_DIGIT && pipe2.frame >= 1) cov[8]++;
        if (pipe2.kind == K_DIGIT && pipe2.on_sprite && pipe2.frame >= 1) cov[9]++;
        if (!pipe2.hs) cov[10]++;
        if (!pipe2.vs) cov[11]++;
    end

    function automatic string goal_name(input int g);
        case (g)
            0: return "day sky in frames 0-1";
            1: return "ground line";
            2: return "light ground";
            3: return "dark ground";
            4: return "night sky in frames 2-3";
            5: return "day sky in frame 4";
            6: return "opaque sprite pixel";
            7: return "transparent sprite pixel";
            8: return "digit ink";
            9: return "digit ink over the sprite";
            10: return "horizontal sync pulse";
            default: return "vertical sync pulse";
        endcase
    endfunction

    task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input logic [BUS_DATA_W-1:0] data);
        chipselect = 1'b1;
        write = 1'b1;
        address = addr;
        writedata = data;
        @(posedge clk);
        #0.5;
        chipselect = 1'b0;
        write = 1'b0;
    endtask

    task automatic wait_for_vblank();
        int cycles;
        cycles = 0;
        while (m_v < `V_ACTIVE) begin
            @(posedge clk);
            #0.5;
            cycles++;
            if (cycles > FRAME_CYCLES) stop_on_timeout("vertical blanking of frame 0");
        end
    endtask

    task automatic wait_for_frame(input int target);
        int cycles;
        cycles = 0;
        while (m_frame < target) begin
            @(posedge clk);
            #0.5;
            cycles++;
            if (cycles > (target + 1) * FRAME_CYCLES) stop_on_timeout("the end of the last frame");
        end
    endtask

    initial begin
        int          missing;
        logic [10:0] sprite_x_pick, sprite_y_pick, score_x_pick, score_y_pick;
        logic [3:0]  score_pick;
        void'($urandom(64));
        reset = 1'b1;
        chipselect = 1'b0;
        write = 1'b0;
        address = '0;
        writedata = '0;
        repeat (8) @(posedge clk);
        #0.5;
        reset = 1'b0;

        // Digit box falls inside the sprite box so the ink overlaps it
        sprite_x_pick = 11'($urandom_range(`H_ACTIVE - `SPRITE_SIZE, 0));
        sprite_y_pick = 11'($urandom_range(`V_ACTIVE - `SPRITE_SIZE, 0));
        score_x_pick = sprite_x_pick + 11'($urandom_range(`SPRITE_SIZE - `FONT_SIZE, 0));
        score_y_pick = sprite_y_pick + 11'($urandom_range(`SPRITE_SIZE - `FONT_SIZE, 0));
        score_pick = 4'($urandom_range(9, 0));

        wait_for_vblank();
        bus_write(REG_SPRITE_X, 32'(sprite_x_pick));
        bus_write(REG_SPRITE_Y, 32'(sprite_y_pick));
        bus_write(REG_SCORE, 32'(score_pick));
        bus_write(REG_SCORE_X, 32'(score_x_pick));
        bus_write(REG_SCORE_Y, 32'(score_y_pick));
        // Unmapped address must change nothing
        bus_write(9'd5, $urandom());

        wait_for_frame(RUN_FRAMES);

        missing = 0;
        for (int g = 0; g < NUM_GOALS; g++) begin
            if (cov[g] == 0) begin
                $display("Never reached: %s", goal_name(g));
                missing++;
            end
        end
        if (missing == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "some checks were never reached");
        end
    end

endmodule

// ==== vga_game_top.sv ====
`timescale 1ns/100ps

module vga_game_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          chipselect,
    input  logic                          write,
    input  logic [bus_pkg::BUS_ADDR_W-1:0] address,
    input  logic [bus_pkg::BUS_DATA_W-1:0] writedata,
    output logic [7:0]                    vga_r,
    output logic [7:0]                    vga_g,
    output logic [7:0]                    vga_b,
    output logic                          vga_hs,
    output logic                          vga_vs,
    output logic                          vga_blank_n,
    output logic                          vga_clk
);

    scan_if       scan ();
    layer_regs_if regs ();

    // Background and sprite-mixed colour between the layers
    logic [7:0] bg_r, bg_g, bg_b;
    logic [7:0] mix_r, mix_g, mix_b;

    vga_timing vga_timing_inst (
        .clk         (clk),
        .reset       (reset),
        .scan        (scan),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_clk     (vga_clk)
    );

    control_regs control_regs_inst (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .regs       (regs)
    );

    sky_ground sky_ground_inst (
        .clk   (clk),
        .reset (reset),
        .scan  (scan),
        .bg_r  (bg_r),
        .bg_g  (bg_g),
        .bg_b  (bg_b)
    );

    sprite_layer sprite_layer_inst (
        .clk   (clk),
        .reset (reset),
        .scan  (scan),
        .regs  (regs),
        .bg_r  (bg_r),
        .bg_g  (bg_g),
        .bg_b  (bg_b),
        .mix_r (mix_r),
        .mix_g (mix_g),
        .mix_b (mix_b)
    );

    score_overlay score_overlay_inst (
        .clk   (clk),
        .reset (reset),
        .scan  (scan),
        .regs  (regs),
        .mix_r (mix_r),
        .mix_g (mix_g),
        .mix_b (mix_b),
        .vga_r (vga_r),
        .vga_g (vga_g),
        .vga_b (vga_b)
    );

endmodule

// ==== score_overlay.sv ====
`timescale 1ns/100ps
`include "vga_params.svh"

module score_overlay (
    input  logic        clk,
    input  logic        reset,
    scan_if.sink        scan,
    layer_regs_if.layer regs,
    input  logic [7:0]  mix_r,
    input  logic [7:0]  mix_g,
    input  logic [7:0]  mix_b,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b
);

    localparam int CW     = `COORD_W;
    localparam int FI     = $clog2(`FONT_SIZE);
    localparam int GLYPH_W = `FONT_SIZE * `FONT_SIZE;

    // Glyph rows top to bottom from the MSB, leftmost column is bit 7
    logic [GLYPH_W-1:0] font_rom [0:9];

    initial begin
        font_rom[0] = 64'h3C66_6E7E_7666_3C00;
        font_rom[1] = 64'h1838_1818_1818_7E00;
        font_rom[2] = 64'h3C66_061C_3066_7E00;
        font_rom[3] = 64'h3C66_061C_0666_3C00;
        font_rom[4] = 64'h0C1C_2C4C_7E0C_0C00;
        font_rom[5] = 64'h7E60_7C06_0666_3C00;
        font_rom[6] = 64'h3C66_607C_6666_3C00;
        font_rom[7] = 64'h7E06_0C18_3030_3000;
        font_rom[8] = 64'h3C66_663C_6666_3C00;
        font_rom[9] = 64'h3C66_663E_0666_3C00;
    end

    logic [CW-1:0]         col_off, row_off;
    logic                  in_box;
    logic                  digit_ok;
    logic [GLYPH_W-1:0]    glyph;
    logic [`FONT_SIZE-1:0] glyph_row;
    logic                  font_hit;
    logic                  font_q;
    logic                  active_q;

    assign col_off = CW'(scan.hcount) - regs.score_x;
    assign row_off = CW'(scan.vcount) - regs.score_y;

    assign in_box = (CW'(scan.hcount) >= regs.score_x) && (col_off < `FONT_SIZE)
                 && (CW'(scan.vcount) >= regs.score_y) && (row_off < `FONT_SIZE);

    // Scores above nine have no glyph
    assign digit_ok  = (regs.score <= 4'd9);
    assign glyph     = digit_ok ? font_rom[regs.score] : '0;
    assign glyph_row = glyph[(`FONT_SIZE - 1 - row_off[FI-1:0]) * `FONT_SIZE +: `FONT_SIZE];
    assign font_hit  = in_box && glyph_row[`FONT_SIZE - 1 - col_off[FI-1:0]];

    // Stage 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            font_q   <= 1'b0;
            active_q <= 1'b0;
        end else begin
            font_q   <= font_hit;
            active_q <= scan.active;
        end
    end

    // Stage 2, digit ink is black
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {vga_r, vga_g, vga_b} <= 24'h000000;
        end else if (!active_q || font_q) begin
            {vga_r, vga_g, vga_b} <= 24'h000000;
        end else begin
            {vga_r, vga_g, vga_b} <= {mix_r, mix_g, mix_b};
        end
    end

endmodule

// ==== sprite_layer.sv ====
`timescale 1ns/100ps
`include "vga_params.svh"

module sprite_layer (
    input  logic        clk,
    input  logic        reset,
    scan_if.sink        scan,
    layer_regs_if.layer regs,
    input  logic [7:0]  bg_r,
    input  logic [7:0]  bg_g,
    input  logic [7:0]  bg_b,
    output logic [7:0]  mix_r,
    output logic [7:0]  mix_g,
    output logic [7:0]  mix_b
);
    import display_pkg::*;

    localparam int CW    = `COORD_W;
    localparam int IDX_W = $clog2(`SPRITE_SIZE);
    localparam int ROW_W = `SPRITE_SIZE * PIXEL_W;

    // One word per sprite row, column 0 in the top 16 bits
    logic [ROW_W-1:0] sprite_rom [0:`SPRITE_SIZE-1];

    initial begin
        $readmemh("sprite_rom.hex", sprite_rom);
    end

    logic [CW-1:0]    col_off, row_off;
    logic             in_box;
    logic [ROW_W-1:0] row_q;
    logic [IDX_W-1:0] col_q;
    logic             hit_q;
    logic [7:0]       bg_r_q, bg_g_q, bg_b_q;
    pixel565_u        pix;
    logic             opaque;

    assign col_off = CW'(scan.hcount) - regs.sprite_x;
    assign row_off = CW'(scan.vcount) - regs.sprite_y;

    assign in_box = (CW'(scan.hcount) >= regs.sprite_x) && (col_off < `SPRITE_SIZE)
                 && (CW'(scan.vcount) >= regs.sprite_y) && (row_off < `SPRITE_SIZE);

    // Stage 1
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= in_box;
        end
    end

    always_ff @(posedge clk) begin
        row_q  <= sprite_rom[row_off[IDX_W-1:0]];
        col_q  <= col_off[IDX_W-1:0];
        bg_r_q <= bg_r;
        bg_g_q <= bg_g;
        bg_b_q <= bg_b;
    end

    assign pix.raw = row_q[(`SPRITE_SIZE - 1 - col_q) * PIXEL_W +: PIXEL_W];
    assign opaque  = (pix.raw != `TRANSPARENT_KEY_A) && (pix.raw != `TRANSPARENT_KEY_B);

    always_comb begin
        if (hit_q && opaque) begin
            mix_r = widen5(pix.fields.red);
            mix_g = widen6(pix.fields.green);
            mix_b = widen5(pix.fields.blue);
        end else begin
            mix_r = bg_r_q;
            mix_g = bg_g_q;
            mix_b = bg_b_q;
        end
    end

endmodule

// ==== sky_ground.sv ====
`timescale 1ns/100ps
`include "vga_params.svh"

module sky_ground (
    input  logic       clk,
    input  logic       reset,
    scan_if.sink       scan,
    output logic [7:0] bg_r,
    output logic [7:0] bg_g,
    output logic [7:0] bg_b
);

    localparam int CNT_W = $clog2(`DAY_NIGHT_FRAMES + 1);

    // Frames begun since the last sky change
    logic [CNT_W-1:0] frame_cnt;
    logic             night;
    logic             toggle;
    logic             night_now;

    assign toggle = scan.frame_start && (frame_cnt == CNT_W'(`DAY_NIGHT_FRAMES));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_cnt <= '0;
            night     <= 1'b0;
        end else if (scan.frame_start) begin
            if (toggle) begin
                night     <= ~night;
                frame_cnt <= CNT_W'(1);
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    // First pixel of a toggling frame already sees the new sky
    assign night_now = night ^ toggle;

    always_comb begin
        if (scan.vcount <= `SKY_LAST_ROW) begin
            if (night_now) begin
                {bg_r, bg_g, bg_b} = {`SKY_NIGHT_R, `SKY_NIGHT_G, `SKY_NIGHT_B};
            end else begin
                {bg_r, bg_g, bg_b} = {`SKY_DAY_R, `SKY_DAY_G, `SKY_DAY_B};
            end
        end else if (scan.vcount == `GROUND_LINE_ROW) begin
            {bg_r, bg_g, bg_b} = 24'h000000;
        end else if (scan.vcount <= `LIGHT_GROUND_LAST_ROW) begin
            {bg_r, bg_g, bg_b} = {`LIGHT_GROUND_R, `LIGHT_GROUND_G, `LIGHT_GROUND_B};
        end else begin
            {bg_r, bg_g, bg_b} = {`DARK_GROUND_R, `DARK_GROUND_G, `DARK_GROUND_B};
        end
    end

endmodule

// ==== control_regs.sv ====
`timescale 1ns/100ps
`include "vga_params.svh"

module control_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          chipselect,
    input  logic                          write,
    input  logic [bus_pkg::BUS_ADDR_W-1:0] address,
    input  logic [bus_pkg::BUS_DATA_W-1:0] writedata,
    layer_regs_if.regs                    regs
);
    import bus_pkg::*;

    localparam int CW = `COORD_W;

    logic wr_en;

    // No wait states, every selected write lands this cycle
    assign wr_en = chipselect && write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs.sprite_x <= CW'(100);
            regs.sprite_y <= CW'(248);
            regs.score    <= 4'd0;
            regs.score_x  <= CW'(25);
            regs.score_y  <= CW'(41);
        end else if (wr_en) begin
            case (address)
                REG_SPRITE_X: regs.sprite_x <= writedata[CW-1:0];
                REG_SPRITE_Y: regs.sprite_y <= writedata[CW-1:0];
                REG_SCORE:    regs.score    <= writedata[3:0];
                REG_SCORE_X:  regs.score_x  <= writedata[CW-1:0];
                REG_SCORE_Y:  regs.score_y  <= writedata[CW-1:0];
                // Unmapped addresses drop the write
                default: ;
            endcase
        end
    end

endmodule

// ==== vga_timing.sv ====
`timescale 1ns/100ps
`include "vga_params.svh"

module vga_timing (
    input  logic  clk,
    input  logic  reset,
    scan_if.source scan,
    output logic  vga_hs,
    output logic  vga_vs,
    output logic  vga_blank_n,
    output logic  vga_clk
);

    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
    localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
    localparam int HW = `HCOUNT_W;
    localparam int VW = `VCOUNT_W;

    logic [HW-1:0] hcount;
    logic [VW-1:0] vcount;
    logic          end_of_line;
    logic          end_of_field;
    logic          hs_now, vs_now, active_now;

    // Sync and blank delay lines, oldest stage drives the pins
    logic [`PIXEL_LATENCY-1:0] hs_pipe;
    logic [`PIXEL_LATENCY-1:0] vs_pipe;
    logic [`PIXEL_LATENCY-1:0] blank_pipe;

    assign end_of_line  = (hcount == HW'(H_TOTAL - 1));
    assign end_of_field = (vcount == VW'(V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
            vcount <= end_of_field ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // Syncs are active low
    assign hs_now = !((hcount >= H_SYNC_START) && (hcount < H_SYNC_START + `H_SYNC));
    assign vs_now = !((vcount >= V_SYNC_START) && (vcount < V_SYNC_START + `V_SYNC));
    assign active_now = (hcount < `H_ACTIVE) && (vcount < `V_ACTIVE);

    assign scan.hcount      = hcount;
    assign scan.vcount      = vcount;
    assign scan.active      = active_now;
    assign scan.frame_start = (hcount == '0) && (vcount == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hs_pipe    <= '1;
            vs_pipe    <= '1;
            blank_pipe <= '0;
        end else begin
            hs_pipe    <= {hs_pipe[`PIXEL_LATENCY-2:0], hs_now};
            vs_pipe    <= {vs_pipe[`PIXEL_LATENCY-2:0], vs_now};
            blank_pipe <= {blank_pipe[`PIXEL_LATENCY-2:0], active_now};
        end
    end

    assign vga_hs      = hs_pipe[`PIXEL_LATENCY-1];
    assign vga_vs      = vs_pipe[`PIXEL_LATENCY-1];
    assign vga_blank_n = blank_pipe[`PIXEL_LATENCY-1];
    // Half-rate pixel clock for the DAC
    assign vga_clk     = hcount[0];

endmodule

// ==== display_ifs.sv ====
`timescale 1ns/100ps
`include "vga_params.svh"

// Scan position broadcast from the timing generator
interface scan_if;
    logic [`HCOUNT_W-1:0] hcount;
    logic [`VCOUNT_W-1:0] vcount;
    logic                 active;
    logic                 frame_start;

    modport source (output hcount, vcount, active, frame_start);
    modport sink (input hcount, vcount, active, frame_start);
endinterface

// Bus-written layer positions and score
interface layer_regs_if;
    logic [`COORD_W-1:0] sprite_x;
    logic [`COORD_W-1:0] sprite_y;
    logic [3:0]          score;
    logic [`COORD_W-1:0] score_x;
    logic [`COORD_W-1:0] score_y;

    modport regs (output sprite_x, sprite_y, score, score_x, score_y);
    modport layer (input sprite_x, sprite_y, score, score_x, score_y);
endinterface

// ==== display_pkg.sv ====
package display_pkg;

    localparam int PIXEL_W = 16;

    // RGB565 layout, red in the top bits
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // Sprite word, compared whole against the keys or split into channels
    typedef union packed {
        logic [PIXEL_W-1:0] raw;
        rgb565_t            fields;
    } pixel565_u;

    // Channel widening to 8 bits, low bits zero
    function automatic logic [7:0] widen5(input logic [4:0] value);
        return {value, 3'b000};
    endfunction

    function automatic logic [7:0] widen6(input logic [5:0] value);
        return {value, 2'b00};
    endfunction

endpackage

// ==== bus_pkg.sv ====
package bus_pkg;

    localparam int BUS_ADDR_W = 9;
    localparam int BUS_DATA_W = 32;

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

    // Register map, one word per register
    localparam bus_addr_t REG_SPRITE_X = 9'd0;
    localparam bus_addr_t REG_SPRITE_Y = 9'd1;
    localparam bus_addr_t REG_SCORE    = 9'd2;
    localparam bus_addr_t REG_SCORE_X  = 9'd3;
    localparam bus_addr_t REG_SCORE_Y  = 9'd4;

endpackage

// ==== vga_params.svh ====
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// Horizontal raster in pixels
`define H_ACTIVE 1280
`define H_FRONT 32
`define H_SYNC 192
`define H_BACK 96

// Vertical raster in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

`define HCOUNT_W 11
`define VCOUNT_W 10
`define COORD_W 11

// Clocks from scan position to RGB at the pins
`define PIXEL_LATENCY 2

// Background row bands
`define SKY_LAST_ROW 279
`define GROUND_LINE_ROW 280
`define LIGHT_GROUND_LAST_ROW 300

`define SKY_DAY_R 8'd135
`define SKY_DAY_G 8'd206
`define SKY_DAY_B 8'd235
`define SKY_NIGHT_R 8'd10
`define SKY_NIGHT_G 8'd10
`define SKY_NIGHT_B 8'd40
`define LIGHT_GROUND_R 8'd139
`define LIGHT_GROUND_G 8'd69
`define LIGHT_GROUND_B 8'd19
`define DARK_GROUND_R 8'd100
`define DARK_GROUND_G 8'd40
`define DARK_GROUND_B 8'd10

// Completed frames between sky toggles
`define DAY_NIGHT_FRAMES 2

`define SPRITE_SIZE 16
// Magenta and white both read as see-through
`define TRANSPARENT_KEY_A 16'hF81F
`define TRANSPARENT_KEY_B 16'hFFFF

`define FONT_SIZE 8

`endif
